/* logic/uart_bridge_pkg.sv */
package uart_bridge_pkg;

  // ****************************************
  // serial payload and host command
  // ****************************************

  typedef logic [7:0] byte_t;

  typedef logic [6:0] addr_t;

  // bit 15 selects write, then address, then write data.
  typedef struct packed {
    logic  is_write;
    addr_t addr;
    byte_t data;
  } cmd_t;

  // ****************************************
  // frame and result records
  // ****************************************

  // one received frame with its line checks.
  typedef struct packed {
    byte_t data;
    logic  parity_ok;
    logic  stop_ok;
  } rx_frame_t;

  // read reply as seen by the host.
  typedef struct packed {
    byte_t data;
    logic  parity_ok;
    logic  timed_out;
  } read_result_t;

  typedef enum logic [2:0] {
    IDLE,
    SEND_HEAD,
    GAP,
    SEND_DATA,
    WAIT_REPLY,
    DELIVER
  } seq_state_t;

endpackage

/* logic/uart_frame_tx.sv */
`timescale 1ns/1ns

module uart_frame_tx #(
  parameter int unsigned clks_per_bit = 434
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   tx_start,
  input  uart_bridge_pkg::byte_t tx_byte,
  output logic                   tx,
  output logic                   tx_busy,
  output logic                   tx_done
);

  localparam int unsigned cnt_w = $clog2(clks_per_bit);

  // stop, parity, data lsb first, start.
  logic [10:0]      frame_sr;
  logic [cnt_w-1:0] baud_cnt;
  logic [3:0]       bit_cnt;
  logic             bit_end;

  assign bit_end = (baud_cnt == cnt_w'(clks_per_bit - 1));

  // line idles high once the stop bit has shifted through.
  assign tx = frame_sr[0];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      frame_sr <= '1;
      tx_busy  <= 1'b0;
      tx_done  <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end
    else
    begin
      tx_done <= 1'b0;
      if (tx_start && !tx_busy)
      begin
        // odd parity over data plus parity bit.
        frame_sr <= {1'b1, ~^tx_byte, tx_byte, 1'b0};
        tx_busy  <= 1'b1;
        baud_cnt <= '0;
        bit_cnt  <= '0;
      end
      else if (tx_busy)
      begin
        if (bit_end)
        begin
          baud_cnt <= '0;
          frame_sr <= {1'b1, frame_sr[10:1]};
          if (bit_cnt == 4'd10)
          begin
            tx_busy <= 1'b0;
            tx_done <= 1'b1;
          end
          else
          begin
            bit_cnt <= bit_cnt + 4'd1;
          end
        end
        else
        begin
          baud_cnt <= baud_cnt + 1'b1;
        end
      end
    end
  end

  // ****************************************
  // checks
  // ****************************************

  a_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
    !tx_busy |-> tx);

endmodule

/* logic/uart_frame_rx.sv */
`timescale 1ns/1ns

module uart_frame_rx #(
  parameter int unsigned clks_per_bit = 434
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       rx,
  output uart_bridge_pkg::rx_frame_t rx_frame,
  output logic                       rx_frame_vld,
  output logic                       rx_active
);

  localparam int unsigned cnt_w  = $clog2(clks_per_bit);
  localparam int unsigned mid_pt = clks_per_bit / 2 - 1;

  logic                   rx_s1;
  logic                   rx_s2;
  logic                   rx_d;
  logic                   start_edge;
  logic                   sample_now;
  logic [cnt_w-1:0]       baud_cnt;
  logic [3:0]             bit_idx;
  uart_bridge_pkg::byte_t data_sr;
  logic                   par_bit;

  // ****************************************
  // synchronizer and edge detect
  // ****************************************

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_d  <= 1'b1;
    end
    else
    begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_d  <= rx_s2;
    end
  end

  assign start_edge = rx_d && !rx_s2 && !rx_active;
  assign sample_now = rx_active && (baud_cnt == cnt_w'(mid_pt));

  // bit_idx 0 is start, 1..8 data, 9 parity, 10 stop.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_active    <= 1'b0;
      rx_frame_vld <= 1'b0;
      baud_cnt     <= '0;
      bit_idx      <= '0;
    end
    else
    begin
      rx_frame_vld <= 1'b0;
      if (start_edge)
      begin
        rx_active <= 1'b1;
        baud_cnt  <= '0;
        bit_idx   <= '0;
      end
      else if (rx_active)
      begin
        if (baud_cnt == cnt_w'(clks_per_bit - 1))
          baud_cnt <= '0;
        else
          baud_cnt <= baud_cnt + 1'b1;
        if (sample_now)
        begin
          // glitch, start bit gone by mid-bit.
          if (bit_idx == 4'd0 && rx_s2)
          begin
            rx_active <= 1'b0;
          end
          else if (bit_idx == 4'd10)
          begin
            rx_active    <= 1'b0;
            rx_frame_vld <= 1'b1;
          end
          else
          begin
            bit_idx <= bit_idx + 4'd1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample_now)
    begin
      if (bit_idx >= 4'd1 && bit_idx <= 4'd8)
        data_sr <= {rx_s2, data_sr[7:1]};
      if (bit_idx == 4'd9)
        par_bit <= rx_s2;
      if (bit_idx == 4'd10)
      begin
        rx_frame.data      <= data_sr;
        rx_frame.parity_ok <= ^{data_sr, par_bit};
        rx_frame.stop_ok   <= rx_s2;
      end
    end
  end

  a_vld_single: assert property (@(posedge clk) disable iff (!rst_n)
    rx_frame_vld |=> !rx_frame_vld);

endmodule

/* logic/cmd_sequencer.sv */
`timescale 1ns/1ns

module cmd_sequencer #(
  parameter int unsigned clks_per_bit       = 434,
  parameter int unsigned gap_cycles         = 100,
  parameter int unsigned reply_timeout_bits = 32
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  uart_bridge_pkg::cmd_t         cmd,
  input  logic                          cmd_vld,
  output logic                          cmd_rdy,
  output logic                          tx_start,
  output uart_bridge_pkg::byte_t        tx_byte,
  input  logic                          tx_busy,
  input  logic                          tx_done,
  input  uart_bridge_pkg::rx_frame_t    rx_frame,
  input  logic                          rx_frame_vld,
  input  logic                          rx_active,
  output uart_bridge_pkg::read_result_t read_result,
  output logic                          read_rdy
);

  localparam int unsigned timeout_cycles = reply_timeout_bits * clks_per_bit;
  localparam int unsigned tmr_w          = $clog2(timeout_cycles + 1);
  localparam int unsigned gap_w          = $clog2(gap_cycles + 1);

  uart_bridge_pkg::seq_state_t state;
  uart_bridge_pkg::cmd_t       cmd_q;
  logic [gap_w-1:0]            gap_cnt;
  logic [tmr_w-1:0]            reply_tmr;
  logic                        reply_expired;

  assign cmd_rdy  = (state == uart_bridge_pkg::IDLE);
  assign read_rdy = (state == uart_bridge_pkg::DELIVER);

  // head byte carries rw flag and address.
  assign tx_byte = (state == uart_bridge_pkg::SEND_DATA) ? cmd_q.data
                                                         : {cmd_q.is_write, cmd_q.addr};

  // timer only runs while no reply frame is in progress.
  assign reply_expired = !rx_active && (reply_tmr == tmr_w'(timeout_cycles - 1));

  // ****************************************
  // control FSM
  // ****************************************

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= uart_bridge_pkg::IDLE;
      tx_start  <= 1'b0;
      gap_cnt   <= '0;
      reply_tmr <= '0;
    end
    else
    begin
      tx_start <= 1'b0;
      case (state)
        uart_bridge_pkg::IDLE:
        begin
          if (cmd_vld)
          begin
            state    <= uart_bridge_pkg::SEND_HEAD;
            tx_start <= 1'b1;
          end
        end
        uart_bridge_pkg::SEND_HEAD:
        begin
          if (tx_done)
          begin
            gap_cnt   <= '0;
            reply_tmr <= '0;
            if (cmd_q.is_write)
              state <= uart_bridge_pkg::GAP;
            else
              state <= uart_bridge_pkg::WAIT_REPLY;
          end
        end
        uart_bridge_pkg::GAP:
        begin
          if (gap_cnt == gap_w'(gap_cycles - 1))
          begin
            state    <= uart_bridge_pkg::SEND_DATA;
            tx_start <= 1'b1;
          end
          else
          begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        uart_bridge_pkg::SEND_DATA:
        begin
          if (tx_done)
            state <= uart_bridge_pkg::IDLE;
        end
        uart_bridge_pkg::WAIT_REPLY:
        begin
          if (rx_frame_vld || reply_expired)
            state <= uart_bridge_pkg::DELIVER;
          else if (!rx_active)
            reply_tmr <= reply_tmr + 1'b1;
        end
        default:
        begin
          state <= uart_bridge_pkg::IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_rdy && cmd_vld)
      cmd_q <= cmd;
    if (state == uart_bridge_pkg::WAIT_REPLY)
    begin
      if (rx_frame_vld)
      begin
        read_result.data      <= rx_frame.data;
        read_result.parity_ok <= rx_frame.parity_ok && rx_frame.stop_ok;
        read_result.timed_out <= 1'b0;
      end
      else if (reply_expired)
      begin
        read_result <= uart_bridge_pkg::read_result_t'{data: '0, parity_ok: 1'b0,
                                                       timed_out: 1'b1};
      end
    end
  end

  a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
    tx_start |-> !tx_busy);

endmodule

/* logic/uart_cmd_bridge.sv */
`timescale 1ns/1ns

module uart_cmd_bridge #(
  parameter int unsigned clks_per_bit       = 434,
  parameter int unsigned gap_cycles         = 100,
  parameter int unsigned reply_timeout_bits = 32
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  uart_bridge_pkg::cmd_t         cmd,
  input  logic                          cmd_vld,
  output logic                          cmd_rdy,
  input  logic                          rx,
  output logic                          tx,
  output uart_bridge_pkg::read_result_t read_result,
  output logic                          read_rdy
);

  logic                       tx_start;
  uart_bridge_pkg::byte_t     tx_byte;
  logic                       tx_busy;
  logic                       tx_done;
  uart_bridge_pkg::rx_frame_t rx_frame;
  logic                       rx_frame_vld;
  logic                       rx_active;

  cmd_sequencer #(
    .clks_per_bit       (clks_per_bit),
    .gap_cycles         (gap_cycles),
    .reply_timeout_bits (reply_timeout_bits)
  ) u_seq (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd          (cmd),
    .cmd_vld      (cmd_vld),
    .cmd_rdy      (cmd_rdy),
    .tx_start     (tx_start),
    .tx_byte      (tx_byte),
    .tx_busy      (tx_busy),
    .tx_done      (tx_done),
    .rx_frame     (rx_frame),
    .rx_frame_vld (rx_frame_vld),
    .rx_active    (rx_active),
    .read_result  (read_result),
    .read_rdy     (read_rdy)
  );

  uart_frame_tx #(
    .clks_per_bit (clks_per_bit)
  ) u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy),
    .tx_done  (tx_done)
  );

  // receiver always listens, sequencer filters by state.
  uart_frame_rx #(
    .clks_per_bit (clks_per_bit)
  ) u_rx (
    .clk          (clk),
    .rst_n        (rst_n),
    .rx           (rx),
    .rx_frame     (rx_frame),
    .rx_frame_vld (rx_frame_vld),
    .rx_active    (rx_active)
  );

endmodule

/* testbench/tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// columns name, command word, reply mode, reply byte, random data, hold next.
// a random row draws the write data or the reply byte from $urandom.
// a hold row presents the next row's command while it is still busy.

task automatic load_vectors();
  add_vec("write_basic",      16'h853c, reply_none, 8'h00, 1'b0, 1'b0);
  add_vec("read_good",        16'h1200, reply_good, 8'ha5, 1'b0, 1'b0);
  add_vec("read_bad_parity",  16'h2300, reply_bad,  8'h5a, 1'b0, 1'b0);
  add_vec("read_no_reply",    16'h3400, reply_none, 8'h00, 1'b0, 1'b0);
  add_vec("write_random",     16'hff00, reply_none, 8'h00, 1'b1, 1'b0);
  add_vec("read_good_random", 16'h0100, reply_good, 8'h00, 1'b1, 1'b0);
  add_vec("read_bad_random",  16'h7f00, reply_bad,  8'h00, 1'b1, 1'b0);
  add_vec("write_held_first", 16'hc07e, reply_none, 8'h00, 1'b0, 1'b1);
  add_vec("read_held_second", 16'h4400, reply_good, 8'h81, 1'b0, 1'b0);
  add_vec("write_zero_held",  16'h8000, reply_none, 8'h00, 1'b0, 1'b1);
  add_vec("write_after_held", 16'h80ff, reply_none, 8'h00, 1'b0, 1'b0);
  add_vec("read_no_reply_2",  16'h5500, reply_none, 8'h00, 1'b0, 1'b0);
endtask

`endif

/* testbench/tb_uart_cmd_bridge.sv */
`timescale 1ns/1ns

module tb_uart_cmd_bridge;

  localparam int unsigned clks_per_bit       = 8;
  localparam int unsigned gap_cycles         = 4;
  localparam int unsigned reply_timeout_bits = 24;
  localparam int          timeout_cycles     = reply_timeout_bits * clks_per_bit;
  localparam int          wait_limit         = 30 * clks_per_bit;

  typedef enum logic [1:0] {reply_none, reply_good, reply_bad} reply_mode_t;

  logic                          clk = 1'b0;
  logic                          rst_n;
  uart_bridge_pkg::cmd_t         cmd;
  logic                          cmd_vld;
  logic                          cmd_rdy;
  logic                          rx;
  logic                          tx;
  uart_bridge_pkg::read_result_t read_result;
  logic                          read_rdy;

  string       vec_name[$];
  logic [15:0] vec_cmd[$];
  reply_mode_t vec_mode[$];
  logic [7:0]  vec_reply[$];
  logic        vec_rand[$];
  logic        vec_hold[$];

  string                         cur_name = "reset";
  logic                          held;
  logic [7:0]                    tx_q[$];
  logic                          mon_busy;
  int                            mon_cnt;
  logic [10:0]                   mon_bits;
  int                            rdy_count = 0;
  uart_bridge_pkg::read_result_t last_result;

  uart_cmd_bridge #(
    .clks_per_bit       (clks_per_bit),
    .gap_cycles         (gap_cycles),
    .reply_timeout_bits (reply_timeout_bits)
  ) u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .cmd_vld     (cmd_vld),
    .cmd_rdy     (cmd_rdy),
    .rx          (rx),
    .tx          (tx),
    .read_result (read_result),
    .read_rdy    (read_rdy)
  );

  always #10 clk = ~clk;

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("mismatch %s: expected %0h, actual %0h", what, expected, actual);
      abort_run();
    end
  endtask

  function automatic void add_vec(input string name, input logic [15:0] word,
                                  input reply_mode_t mode, input logic [7:0] reply,
                                  input logic rnd, input logic hold);
    vec_name.push_back(name);
    vec_cmd.push_back(word);
    vec_mode.push_back(mode);
    vec_reply.push_back(reply);
    vec_rand.push_back(rnd);
    vec_hold.push_back(hold);
  endfunction

  `include "tb_vectors.svh"

  // ****************************************
  // line models
  // ****************************************

  // decode tx frames, sampling mid-bit.
  always @(negedge clk)
  begin
    if (!rst_n)
      mon_busy = 1'b0;
    else if (!mon_busy && !tx)
    begin
      mon_busy = 1'b1;
      mon_cnt  = 0;
    end
    else if (mon_busy)
    begin
      mon_cnt = mon_cnt + 1;
      if (mon_cnt % clks_per_bit == clks_per_bit / 2)
      begin
        mon_bits[mon_cnt / clks_per_bit] = tx;
        if (mon_cnt / clks_per_bit == 10)
        begin
          check_value({cur_name, " tx start bit"}, 0, mon_bits[0]);
          check_value({cur_name, " tx odd parity"}, 1, ^mon_bits[9:1]);
          check_value({cur_name, " tx stop bit"}, 1, mon_bits[10]);
          tx_q.push_back(mon_bits[8:1]);
          mon_busy = 1'b0;
        end
      end
    end
  end

  always @(negedge clk)
  begin
    if (rst_n && read_rdy)
    begin
      rdy_count   <= rdy_count + 1;
      last_result <= read_result;
    end
  end

  task automatic send_reply(input logic [7:0] value, input logic corrupt);
    logic [10:0] bits;
    int          b;
    bits = {1'b1, (~^value) ^ corrupt, value, 1'b0};
    @(posedge clk);
    #2;
    for (b = 0; b < 11; b++)
    begin
      rx = bits[b];
      repeat (clks_per_bit) @(posedge clk);
      #2;
    end
    rx = 1'b1;
  endtask

  // ****************************************
  // waits and stimulus
  // ****************************************

  task automatic wait_cmd_rdy(input logic level, input int limit);
    int n;
    n = 0;
    while (cmd_rdy !== level && n < limit)
    begin
      @(negedge clk);
      n++;
    end
    if (cmd_rdy !== level)
    begin
      $display("timeout: cmd_rdy never went to %0b in %s", level, cur_name);
      abort_run();
    end
  endtask

  // which 0 counts decoded tx frames, which 1 counts read_rdy pulses.
  task automatic wait_for_count(input logic which, input int target, input int limit);
    int n;
    n = 0;
    while ((which ? rdy_count : tx_q.size()) < target && n < limit)
    begin
      @(negedge clk);
      n++;
    end
    if ((which ? rdy_count : tx_q.size()) < target)
    begin
      $display("timeout: %s not seen within %0d cycles in %s",
               which ? "read_rdy pulse" : "tx frame", limit, cur_name);
      abort_run();
    end
  endtask

  task automatic apply_vector(input int i);
    int   n0;
    int   r0;
    logic exp_ok;
    cur_name = vec_name[i];
    wait_cmd_rdy(1'b1, wait_limit);
    n0 = tx_q.size();
    r0 = rdy_count;
    if (!held)
    begin
      @(posedge clk);
      #2;
      cmd     = uart_bridge_pkg::cmd_t'(vec_cmd[i]);
      cmd_vld = 1'b1;
    end
    @(posedge clk);
    #2;
    held = vec_hold[i];
    if (vec_hold[i])
      cmd = uart_bridge_pkg::cmd_t'(vec_cmd[i + 1]);
    else
      cmd_vld = 1'b0;
    @(negedge clk);
    check_value({cur_name, " cmd_rdy after accept"}, 0, cmd_rdy);
    if (vec_cmd[i][15])
    begin
      wait_cmd_rdy(1'b1, wait_limit);
      check_value({cur_name, " frame count"}, n0 + 2, tx_q.size());
      check_value({cur_name, " head byte"}, vec_cmd[i][15:8], tx_q[n0]);
      check_value({cur_name, " data byte"}, vec_cmd[i][7:0], tx_q[n0 + 1]);
      check_value({cur_name, " read_rdy pulses"}, r0, rdy_count);
    end
    else
    begin
      wait_for_count(1'b0, n0 + 1, 12 * clks_per_bit + 8);
      check_value({cur_name, " head byte"}, vec_cmd[i][15:8], tx_q[n0]);
      if (vec_mode[i] != reply_none)
      begin
        repeat (clks_per_bit) @(posedge clk);
        send_reply(vec_reply[i], vec_mode[i] == reply_bad);
      end
      wait_for_count(1'b1, r0 + 1, 2 * timeout_cycles);
      exp_ok = (vec_mode[i] == reply_good);
      if (vec_mode[i] == reply_none)
        check_value({cur_name, " result data"}, 0, last_result.data);
      else
        check_value({cur_name, " result data"}, vec_reply[i], last_result.data);
      check_value({cur_name, " parity_ok"}, exp_ok, last_result.parity_ok);
      check_value({cur_name, " timed_out"}, vec_mode[i] == reply_none,
                  last_result.timed_out);
      wait_cmd_rdy(1'b1, wait_limit);
      check_value({cur_name, " frame count"}, n0 + 1, tx_q.size());
      check_value({cur_name, " read_rdy pulses"}, r0 + 1, rdy_count);
    end
  endtask

  initial
  begin
    int          i;
    logic [15:0] word;
    rst_n   = 1'b0;
    cmd     = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    held    = 1'b0;
    void'($urandom(32'h3f31_ee93));
    load_vectors();
    for (i = 0; i < vec_name.size(); i++)
    begin
      word = vec_cmd[i];
      if (vec_rand[i] && word[15])
        word[7:0] = 8'($urandom);
      else if (vec_rand[i])
        vec_reply[i] = 8'($urandom);
      vec_cmd[i] = word;
    end
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("after_reset tx", 1, tx);
    check_value("after_reset cmd_rdy", 1, cmd_rdy);
    check_value("after_reset read_rdy", 0, read_rdy);
    for (i = 0; i < vec_name.size(); i++)
      apply_vector(i);
    $display("Test completed successfully");
    $finish;
  end

endmodule

/* project.f */
+incdir+testbench
logic/uart_bridge_pkg.sv
logic/uart_frame_tx.sv
logic/uart_frame_rx.sv
logic/cmd_sequencer.sv
logic/uart_cmd_bridge.sv
testbench/tb_uart_cmd_bridge.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module tb_uart_cmd_bridge -o sim_uart_cmd_bridge

out=$(./obj_dir/sim_uart_cmd_bridge 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
  exit 0
fi
exit 1
